/* Makefile */
# Verilator regression for the out of order core
# override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= oooCoreTb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Regression passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* all.f */
design/oooPkg.sv
design/decodeRename.sv
design/aluStation.sv
design/aluUnit.sv
design/reorderBuffer.sv
design/oooCore.sv
verification/oooCoreTb.sv

/* design/aluStation.sv */
// ====================================================================
// four entry ALU reservation station, wakeup from the data bus
// oldest ready entry issues, ages are kept compact from 0 (oldest)
// a slot granted this cycle may be refilled on the same edge
// ====================================================================
`timescale 1ns/1ps
`default_nettype none

module aluStation import oooPkg::*; (
  input  logic     clk,
  input  logic     rstN,
  input  logic     dispatch,
  input  dispatchT dispatchInfo,
  output logic     rsFull,
  input  cdbT      cdb,
  output issueT    issue,
  output logic     issueValid
);

  typedef logic [$clog2(RS_DEPTH)-1:0] rsIdxT;

  logic [RS_DEPTH-1:0] busy;
  rsIdxT               age [RS_DEPTH];
  dispatchT            slot [RS_DEPTH];

  logic [RS_DEPTH-1:0] ready;
  logic [RS_DEPTH-1:0] grant;
  logic [RS_DEPTH-1:0] freeSlot;
  logic [RS_DEPTH-1:0] oldestReady;
  rsIdxT               grantIdx;
  rsIdxT               fillIdx;
  rsIdxT               fillAge;

  always_comb begin
    for (int i = 0; i < RS_DEPTH; i++) begin
      ready[i] = busy[i] && slot[i].src1.ready && slot[i].src2.ready;
    end
  end

  // oldest ready means smallest age
  always_comb begin
    issueValid = 1'b0;
    grantIdx   = '0;
    for (int i = 0; i < RS_DEPTH; i++) begin
      if (ready[i] && (!issueValid || age[i] < age[grantIdx])) begin
        issueValid = 1'b1;
        grantIdx   = rsIdxT'(i);
      end
    end
    for (int i = 0; i < RS_DEPTH; i++) begin
      grant[i] = issueValid && grantIdx == rsIdxT'(i);
    end
  end

  // ready entries that hold the winning age
  always_comb begin
    for (int i = 0; i < RS_DEPTH; i++) begin
      oldestReady[i] = ready[i] && age[i] == age[grantIdx];
    end
  end

  // lowest free slot, counting the one leaving now
  always_comb begin
    freeSlot = ~busy | grant;
    fillIdx  = '0;
    for (int i = RS_DEPTH - 1; i >= 0; i--) begin
      if (freeSlot[i]) begin
        fillIdx = rsIdxT'(i);
      end
    end
    // newcomer sits behind every entry that stays
    fillAge = rsIdxT'($countones(busy & ~grant));
  end

  assign rsFull = (&busy) && !issueValid;

  assign issue = '{tag:  slot[grantIdx].tag,
                   op:   slot[grantIdx].op,
                   src1: slot[grantIdx].src1.value,
                   src2: slot[grantIdx].src2.value};

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      busy <= '0;
      for (int i = 0; i < RS_DEPTH; i++) begin
        age[i] <= '0;
      end
    end else begin
      for (int i = 0; i < RS_DEPTH; i++) begin
        if (grant[i]) begin
          busy[i] <= 1'b0;
        end else if (busy[i] && issueValid && age[i] > age[grantIdx]) begin
          // close the gap left by the issued entry
          age[i] <= age[i] - 1'b1;
        end
      end
      if (dispatch) begin
        busy[fillIdx] <= 1'b1;
        age[fillIdx]  <= fillAge;
      end
    end
  end

  // operand wakeup, then the new entry write
  always_ff @(posedge clk) begin
    for (int i = 0; i < RS_DEPTH; i++) begin
      if (busy[i] && cdb.valid && !slot[i].src1.ready && slot[i].src1.tag == cdb.tag) begin
        slot[i].src1.ready <= 1'b1;
        slot[i].src1.value <= cdb.value;
      end
      if (busy[i] && cdb.valid && !slot[i].src2.ready && slot[i].src2.tag == cdb.tag) begin
        slot[i].src2.ready <= 1'b1;
        slot[i].src2.value <= cdb.value;
      end
    end
    if (dispatch) begin
      slot[fillIdx] <= dispatchInfo;
    end
  end

  // decode must hold off while the station is full
  noDispatchWhenFull: assert property (@(posedge clk) disable iff (!rstN)
    dispatch |-> !rsFull);

  // distinct ages leave only one oldest ready entry
  oneGrant: assert property (@(posedge clk) disable iff (!rstN)
    $onehot0(oldestReady));

endmodule

`default_nettype wire

/* design/aluUnit.sv */
// ====================================================================
// single cycle integer ALU, result registered onto the data bus
// always accepts, shift amounts use the low five bits of operand two
// ====================================================================
`timescale 1ns/1ps
`default_nettype none

module aluUnit import oooPkg::*; (
  input  logic  clk,
  input  logic  rstN,
  input  issueT issue,
  input  logic  issueValid,
  output cdbT   cdb
);

  wordT       result;
  logic [4:0] shamt;
  logic       busValid;
  robTagT     busTag;
  wordT       busValue;

  assign shamt = issue.src2[4:0];

  always_comb begin
    case (issue.op)
      aluAdd:  result = issue.src1 + issue.src2;
      aluSub:  result = issue.src1 - issue.src2;
      aluAnd:  result = issue.src1 & issue.src2;
      aluOr:   result = issue.src1 | issue.src2;
      aluXor:  result = issue.src1 ^ issue.src2;
      aluSlt:  result = {31'b0, $signed(issue.src1) < $signed(issue.src2)};
      aluSltu: result = {31'b0, issue.src1 < issue.src2};
      aluSll:  result = issue.src1 << shamt;
      aluSrl:  result = issue.src1 >> shamt;
      // arithmetic shift keeps the sign
      aluSra:  result = wordT'($signed(issue.src1) >>> shamt);
      aluPass: result = issue.src2;
      default: result = '0;
    endcase
  end

  // bus valid one cycle after issue
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      busValid <= 1'b0;
    end else begin
      busValid <= issueValid;
    end
  end

  always_ff @(posedge clk) begin
    if (issueValid) begin
      busTag   <= issue.tag;
      busValue <= result;
    end
  end

  assign cdb = '{valid: busValid, tag: busTag, value: busValue};

endmodule

`default_nettype wire

/* design/decodeRename.sv */
// ====================================================================
// decode, register file, register status table and operand read
// only ALU ops, their immediate forms and LUI are decoded
// other encodings are not detected and give undefined behaviour
// ====================================================================
`timescale 1ns/1ps
`default_nettype none

module decodeRename import oooPkg::*; (
  input  logic     clk,
  input  logic     rstN,
  input  wordT     instr,
  input  logic     instrValid,
  output logic     stall,
  input  logic     robFull,
  input  logic     rsFull,
  input  robTagT   robTail,
  output logic     dispatch,
  output dispatchT dispatchInfo,
  output allocT    allocInfo,
  output robTagT   readTag1,
  output robTagT   readTag2,
  input  logic     readDone1,
  input  logic     readDone2,
  input  wordT     readValue1,
  input  wordT     readValue2,
  input  cdbT      cdb,
  input  commitT   commit,
  input  robTagT   commitTag
);

  // architectural state plus rename status
  wordT        regFile [32];
  logic [31:0] statusValid;
  robTagT      statusTag [32];

  logic [6:0] opcode;
  logic [2:0] funct3;
  regIdxT     rs1;
  regIdxT     rs2;
  regIdxT     rd;
  logic       isRegOp;
  logic       isLui;
  logic       regWrite;
  aluOpT      aluOp;
  wordT       immI;
  wordT       immU;
  operandT    src1;
  operandT    src2;

  // operand from register file, finished rob entry or live bus
  function automatic operandT resolve(input regIdxT idx, input wordT regValue,
                                      input logic pending, input robTagT tag,
                                      input logic robDone, input wordT robValue,
                                      input cdbT bus);
    operandT op;
    op.ready = 1'b1;
    op.tag   = tag;
    op.value = regValue;
    if (idx == '0) begin
      op.value = '0;
    end else if (pending) begin
      if (robDone) begin
        op.value = robValue;
      end else if (bus.valid && bus.tag == tag) begin
        op.value = bus.value;
      end else begin
        // still in flight, wait on the tag
        op.ready = 1'b0;
        op.value = '0;
      end
    end
    return op;
  endfunction

  assign opcode  = instr[6:0];
  assign funct3  = instr[14:12];
  assign rd      = instr[11:7];
  assign rs1     = instr[19:15];
  assign rs2     = instr[24:20];
  assign isRegOp = opcode == 7'b0110011;
  assign isLui   = opcode == 7'b0110111;
  assign immI    = {{20{instr[31]}}, instr[31:20]};
  assign immU    = {instr[31:12], 12'b0};

  // x0 never takes a status entry
  assign regWrite = rd != '0;

  always_comb begin
    case (funct3)
      3'b000:  aluOp = (isRegOp && instr[30]) ? aluSub : aluAdd;
      3'b001:  aluOp = aluSll;
      3'b010:  aluOp = aluSlt;
      3'b011:  aluOp = aluSltu;
      3'b100:  aluOp = aluXor;
      3'b101:  aluOp = instr[30] ? aluSra : aluSrl;
      3'b110:  aluOp = aluOr;
      default: aluOp = aluAnd;
    endcase
    if (isLui) begin
      aluOp = aluPass;
    end
  end

  assign readTag1 = statusTag[rs1];
  assign readTag2 = statusTag[rs2];

  always_comb begin
    src1 = resolve(rs1, regFile[rs1], statusValid[rs1], statusTag[rs1],
                   readDone1, readValue1, cdb);
    // rs1 field is immediate bits on LUI
    if (isLui) begin
      src1 = '{ready: 1'b1, tag: '0, value: '0};
    end
    if (isRegOp) begin
      src2 = resolve(rs2, regFile[rs2], statusValid[rs2], statusTag[rs2],
                     readDone2, readValue2, cdb);
    end else begin
      src2 = '{ready: 1'b1, tag: '0, value: isLui ? immU : immI};
    end
  end

  assign stall        = robFull || rsFull;
  assign dispatch     = instrValid && !stall;
  assign dispatchInfo = '{tag: robTail, op: aluOp, src1: src1, src2: src2};
  assign allocInfo    = '{regWrite: regWrite, dest: rd};

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      statusValid <= '0;
      for (int i = 0; i < 32; i++) begin
        regFile[i] <= '0;
      end
    end else begin
      if (commit.valid && commit.regWrite) begin
        regFile[commit.dest] <= commit.value;
        // clear only if no younger writer renamed it since
        if (statusTag[commit.dest] == commitTag) begin
          statusValid[commit.dest] <= 1'b0;
        end
      end
      // rename on accept, overrides a same cycle clear
      if (dispatch && regWrite) begin
        statusValid[rd] <= 1'b1;
      end
    end
  end

  // tag only matters while statusValid is set
  always_ff @(posedge clk) begin
    if (dispatch && regWrite) begin
      statusTag[rd] <= robTail;
    end
  end

endmodule

`default_nettype wire

/* design/oooCore.sv */
// ====================================================================
// out of order core top, RV32I ALU subset and LUI only
// no fetch, branches or memory ops; instructions come on a strobe
// source must hold instr while stall is high
// ====================================================================
`timescale 1ns/1ps
`default_nettype none

module oooCore import oooPkg::*; (
  input  logic   clk,
  input  logic   rstN,
  input  wordT   instr,
  input  logic   instrValid,
  output logic   stall,
  output commitT commit
);

  // decode to station and rob
  logic     dispatch;
  dispatchT dispatchInfo;
  allocT    allocInfo;
  logic     robFull;
  logic     rsFull;
  robTagT   robTail;

  // rob operand read ports
  robTagT   readTag1;
  robTagT   readTag2;
  logic     readDone1;
  logic     readDone2;
  wordT     readValue1;
  wordT     readValue2;

  // execute and completion
  issueT    issue;
  logic     issueValid;
  cdbT      cdb;
  robTagT   commitTag;

  decodeRename decodeRename_i (
    .clk          (clk),
    .rstN         (rstN),
    .instr        (instr),
    .instrValid   (instrValid),
    .stall        (stall),
    .robFull      (robFull),
    .rsFull       (rsFull),
    .robTail      (robTail),
    .dispatch     (dispatch),
    .dispatchInfo (dispatchInfo),
    .allocInfo    (allocInfo),
    .readTag1     (readTag1),
    .readTag2     (readTag2),
    .readDone1    (readDone1),
    .readDone2    (readDone2),
    .readValue1   (readValue1),
    .readValue2   (readValue2),
    .cdb          (cdb),
    .commit       (commit),
    .commitTag    (commitTag)
  );

  aluStation aluStation_i (
    .clk          (clk),
    .rstN         (rstN),
    .dispatch     (dispatch),
    .dispatchInfo (dispatchInfo),
    .rsFull       (rsFull),
    .cdb          (cdb),
    .issue        (issue),
    .issueValid   (issueValid)
  );

  aluUnit aluUnit_i (
    .clk        (clk),
    .rstN       (rstN),
    .issue      (issue),
    .issueValid (issueValid),
    .cdb        (cdb)
  );

  // allocation shares the dispatch strobe
  reorderBuffer reorderBuffer_i (
    .clk        (clk),
    .rstN       (rstN),
    .alloc      (dispatch),
    .allocInfo  (allocInfo),
    .robTail    (robTail),
    .robFull    (robFull),
    .cdb        (cdb),
    .readTag1   (readTag1),
    .readTag2   (readTag2),
    .readDone1  (readDone1),
    .readDone2  (readDone2),
    .readValue1 (readValue1),
    .readValue2 (readValue2),
    .commit     (commit),
    .commitTag  (commitTag)
  );

endmodule

`default_nettype wire

/* design/oooPkg.sv */
// ====================================================================
// sizes, vector types and bus records shared by every core block
// ROB_DEPTH must stay a power of two, tags wrap by plain overflow
// ====================================================================
`default_nettype none

package oooPkg;

  // reorder buffer and reservation station sizes
  localparam int ROB_DEPTH = 8;
  localparam int RS_DEPTH  = 4;

  typedef logic [31:0] wordT;
  typedef logic [4:0]  regIdxT;
  typedef logic [2:0]  robTagT;

  // pass returns operand two untouched, used for LUI
  typedef enum logic [3:0] {
    aluAdd, aluSub, aluAnd, aluOr, aluXor,
    aluSlt, aluSltu, aluSll, aluSrl, aluSra,
    aluPass
  } aluOpT;

  // tag is only meaningful while not ready
  typedef struct packed {
    logic   ready;
    robTagT tag;
    wordT   value;
  } operandT;

  typedef struct packed {
    robTagT  tag;
    aluOpT   op;
    operandT src1;
    operandT src2;
  } dispatchT;

  typedef struct packed {
    robTagT tag;
    aluOpT  op;
    wordT   src1;
    wordT   src2;
  } issueT;

  typedef struct packed {
    logic   valid;
    robTagT tag;
    wordT   value;
  } cdbT;

  // regWrite low when the destination is x0
  typedef struct packed {
    logic   valid;
    logic   regWrite;
    regIdxT dest;
    wordT   value;
  } commitT;

  typedef struct packed {
    logic   regWrite;
    regIdxT dest;
  } allocT;

endpackage

`default_nettype wire

/* design/reorderBuffer.sv */
// ====================================================================
// eight entry circular reorder buffer, one commit per cycle
// tag is the entry index, pointers wrap by overflow
// read ports return the stored result of a finished entry
// ====================================================================
`timescale 1ns/1ps
`default_nettype none

module reorderBuffer import oooPkg::*; (
  input  logic   clk,
  input  logic   rstN,
  input  logic   alloc,
  input  allocT  allocInfo,
  output robTagT robTail,
  output logic   robFull,
  input  cdbT    cdb,
  input  robTagT readTag1,
  input  robTagT readTag2,
  output logic   readDone1,
  output logic   readDone2,
  output wordT   readValue1,
  output wordT   readValue2,
  output commitT commit,
  output robTagT commitTag
);

  logic [ROB_DEPTH-1:0]       done;
  allocT                      entInfo [ROB_DEPTH];
  wordT                       entValue [ROB_DEPTH];
  robTagT                     head;
  robTagT                     tail;
  logic [$clog2(ROB_DEPTH):0] count;
  logic                       retire;

  assign robTail = tail;
  assign robFull = count == ROB_DEPTH;

  // head leaves as soon as its result is in
  assign retire    = count != '0 && done[head];
  assign commitTag = head;
  assign commit    = '{valid:    retire,
                       regWrite: entInfo[head].regWrite,
                       dest:     entInfo[head].dest,
                       value:    entValue[head]};

  // operand forwarding for decode
  assign readDone1  = done[readTag1];
  assign readDone2  = done[readTag2];
  assign readValue1 = entValue[readTag1];
  assign readValue2 = entValue[readTag2];

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
      done  <= '0;
    end else begin
      if (alloc) begin
        done[tail] <= 1'b0;
        tail       <= tail + 1'b1;
      end
      if (cdb.valid) begin
        done[cdb.tag] <= 1'b1;
      end
      if (retire) begin
        head <= head + 1'b1;
      end
      case ({alloc, retire})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // destination at allocation, value at completion
  always_ff @(posedge clk) begin
    if (alloc) begin
      entInfo[tail] <= allocInfo;
    end
    if (cdb.valid) begin
      entValue[cdb.tag] <= cdb.value;
    end
  end

  // decode stalls on robFull, so this ties the two blocks
  noAllocWhenFull: assert property (@(posedge clk) disable iff (!rstN)
    alloc |-> !robFull);

  // a broadcast tag must sit between head and tail
  completeOnlyLive: assert property (@(posedge clk) disable iff (!rstN)
    cdb.valid |-> (robTagT'(cdb.tag - head) < count));

endmodule

`default_nettype wire

/* verification/coreStimulus.mem */
// instruction _ destination register _ expected committed value _ idle cycles after
// idle FF means a random count of 0 to 3
00500093_01_00000005_02
FFD00113_02_FFFFFFFD_01
123451B7_03_12345000_FF
00208233_04_00000002_00
402082B3_05_00000008_01
00112333_06_00000001_00
001133B3_07_00000000_FF
0011C433_08_12345005_00
0021E4B3_09_FFFFFFFD_00
0021F533_0A_12345000_01
001095B3_0B_000000A0_00
00115633_0C_07FFFFFF_FF
401156B3_0D_FFFFFFFF_00
FFF1C713_0E_EDCBAFFF_00
00012793_0F_00000001_02
FFF0B813_10_00000001_00
00409893_11_00000050_FF
40115913_12_FFFFFFFE_00
7F00E993_13_000007F5_04
00001B37_16_00001000_00
001B0B13_16_00001001_00
001B1B13_16_00002002_00
016B0BB3_17_00004004_00
401B8B33_16_00003FFF_00
017B4C33_18_00007FFB_00
402C5C13_18_00001FFE_00
016C6CB3_19_00003FFF_00
018CBD33_1A_00000000_00
01AC8DB3_1B_00003FFF_00
12300E13_1C_00000123_00
FFFFFEB7_1D_FFFFF000_00
00708013_00_0000000C_00
01C00F33_1E_00000123_00

/* verification/oooCoreTb.sv */
// ======================================================================
// testbench for the out of order core, run from the project root
// stimulus and expected commits come from verification/coreStimulus.mem
// NUM_TESTS must match the number of data lines in that file
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

module oooCoreTb import oooPkg::*; ();

  localparam int NUM_TESTS      = 33;
  localparam int TIMEOUT_CYCLES = 20 * NUM_TESTS + 100;

  // one stimulus line, same field order as the file
  typedef struct packed {
    wordT       instr;
    logic [7:0] dest;
    wordT       value;
    logic [7:0] idle;
  } stimT;

  logic   clk;
  logic   rstN;
  wordT   instr;
  logic   instrValid;
  logic   stall;
  commitT commit;

  logic [79:0] stimMem [NUM_TESTS];
  stimT        driveLine;
  stimT        checkLine;
  integer      seed;
  int          idleCycles;
  int          commitIdx;
  int          cycleCount;
  int          testErrors;
  int          passCount;
  int          failCount;
  logic        sawStall;

  oooCore dut_i (
    .clk        (clk),
    .rstN       (rstN),
    .instr      (instr),
    .instrValid (instrValid),
    .stall      (stall),
    .commit     (commit)
  );

  initial begin
    clk = 1'b0;
  end

  always #50 clk = ~clk;

  // mismatch gives an ERR line and marks the current test
  task automatic compareValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
    if (actual !== expected) begin
      $display("ERR %s expected %h actual %h", name, expected, actual);
      testErrors++;
    end
  endtask

  // one line per finished test
  task automatic finishTest(input string name, input string detail);
    if (testErrors == 0) begin
      passCount++;
      $display("ok   %s %s", name, detail);
    end else begin
      failCount++;
      $display("FAIL %s", name);
    end
    testErrors = 0;
  endtask

  // commits must come back in program order, one per file line
  always @(negedge clk) begin
    if (rstN && commit.valid) begin
      if (commitIdx >= NUM_TESTS) begin
        $display("FAIL extra commit after the last stimulus line");
        failCount++;
      end else begin
        checkLine = stimMem[commitIdx];
        compareValue($sformatf("test%0d dest", commitIdx + 1),
                     32'(checkLine.dest), 32'(commit.dest));
        // x0 destination never writes the register file
        compareValue($sformatf("test%0d regWrite", commitIdx + 1),
                     32'(checkLine.dest != 8'd0), 32'(commit.regWrite));
        compareValue($sformatf("test%0d value", commitIdx + 1),
                     checkLine.value, commit.value);
        finishTest($sformatf("test%0d", commitIdx + 1),
                   $sformatf("x%0d = %h", commit.dest, commit.value));
      end
      commitIdx++;
    end
  end

  // hard stop if commits never arrive or stall sticks
  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount >= TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles, only %0d of %0d instructions committed",
               cycleCount, commitIdx, NUM_TESTS);
      failCount++;
      $display("tests: %0d pass, %0d fail", passCount, failCount);
      $display("Regression failed");
      $finish;
    end
  end

  initial begin
    seed       = 59975;
    rstN       = 1'b0;
    instr      = '0;
    instrValid = 1'b0;
    commitIdx  = 0;
    cycleCount = 0;
    testErrors = 0;
    passCount  = 0;
    failCount  = 0;
    sawStall   = 1'b0;
    $readmemh("verification/coreStimulus.mem", stimMem);

    repeat (2) @(posedge clk);
    #1;
    rstN = 1'b1;

    // idle core after reset
    repeat (3) begin
      @(negedge clk);
      compareValue("reset commit.valid", 32'd0, 32'(commit.valid));
      compareValue("reset stall", 32'd0, 32'(stall));
    end
    finishTest("reset", "quiet after reset");

    @(posedge clk);
    #1;
    for (int i = 0; i < NUM_TESTS; i++) begin
      driveLine  = stimMem[i];
      instr      = driveLine.instr;
      instrValid = 1'b1;
      // held until a cycle without stall takes it
      @(negedge clk);
      while (stall) begin
        sawStall = 1'b1;
        @(negedge clk);
      end
      @(posedge clk);
      #1;
      instrValid = 1'b0;
      if (driveLine.idle == 8'hFF) begin
        idleCycles = {$random(seed)} % 4;
      end else begin
        idleCycles = int'(driveLine.idle);
      end
      repeat (idleCycles) begin
        @(posedge clk);
        #1;
      end
    end

    while (commitIdx < NUM_TESTS) begin
      @(posedge clk);
    end
    // a few more cycles to catch a duplicate commit
    repeat (10) @(posedge clk);

    // back to back dependent chain has to fill the station
    compareValue("burst stall seen", 32'd1, 32'(sawStall));
    compareValue("burst commit count", 32'(NUM_TESTS), 32'(commitIdx));
    finishTest("burst", "stall raised, nothing lost");

    $display("tests: %0d pass, %0d fail", passCount, failCount);
    if (failCount == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
